// ==== compile.f ====
src/rv_pkg.sv
src/rv_stage_bus.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_execute.sv
src/rv_writeback.sv
src/rv_hazard.sv
src/rv_core.sv
tb/tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and search the log for the pass line
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -f compile.f --top-module tb_rv_core \
  -o tb_rv_core > build.log 2>&1 &&
./obj_dir/tb_rv_core > sim.log 2>&1
grep -q "Done: no errors" sim.log && echo "PASS" || { echo "FAIL, see build.log and sim.log"; exit 1; }

// ==== tb/tb_rv_core.sv ====
`timescale 1ns/1ns

module tb_rv_core;
  import rv_pkg::*;

  // ----------------------------------------
  // Table sizes and limits
  // ----------------------------------------

  localparam int NUM_ROWS       = 4;
  localparam int MAX_PROG       = 16;
  localparam int MAX_STORES     = 8;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * (MAX_PROG * 4 + 30);
  localparam word_t DATA_ADDR   = 32'h0000_0100;

  logic  clk        = 1'b0;
  logic  rst_n      = 1'b0;
  word_t imem_rdata = '0;
  word_t dmem_rdata = '0;
  logic  imem_ren;
  word_t imem_raddr;
  logic  dmem_ren;
  word_t dmem_raddr;
  logic  dmem_we;
  word_t dmem_waddr;
  word_t dmem_wdata;
  logic  ebreak;

  // Program table with the data word at 0x100 and the expected stores of each row
  word_t prog_tab [NUM_ROWS][MAX_PROG];
  word_t init_tab [NUM_ROWS];
  word_t exp_addr [NUM_ROWS][MAX_STORES];
  word_t exp_data [NUM_ROWS][MAX_STORES];
  int    exp_n    [NUM_ROWS];

  // Memory contents seen by the core
  word_t imem [MAX_PROG];
  word_t data_word;
  // Stores seen on the data port, in order
  word_t got_addr [$];
  word_t got_data [$];

  int seed        = 54;
  int cycle_count = 0;

  rv_core #(.reset_pc(32'h0000_0000)) dut0 (
    .clk, .rst_n, .imem_ren, .imem_raddr, .imem_rdata,
    .dmem_ren, .dmem_raddr, .dmem_rdata,
    .dmem_we, .dmem_waddr, .dmem_wdata, .ebreak
  );

  initial begin
    forever #4 clk = ~clk;
  end

  // ----------------------------------------
  // Memory models with one cycle of read latency
  // ----------------------------------------

  always @(posedge clk) begin
    if (imem_ren) begin
      imem_rdata <= imem[imem_raddr[5:2]];
    end
    // Outside the data word the address itself is returned inverted
    if (dmem_ren) begin
      dmem_rdata <= (dmem_raddr == DATA_ADDR) ? data_word : ~dmem_raddr;
    end
    if (!rst_n) begin
      got_addr.delete();
      got_data.delete();
    end else if (dmem_we) begin
      got_addr.push_back(dmem_waddr);
      got_data.push_back(dmem_wdata);
    end
  end

  // Whole run is bounded
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      abort_run("Core did not reach ebreak within the cycle limit");
    end
  end

  // ----------------------------------------
  // Instruction encoders
  // ----------------------------------------

  function automatic word_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3,
                                   input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd,
                                   input opcode_e opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  // SW only
  function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                   input reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  // BEQ only with a byte offset from the branch
  function automatic word_t b_type(input logic [12:0] off, input reg_idx_t rs2,
                                   input reg_idx_t rs1);
    return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], OPC_BRANCH};
  endfunction

  // ----------------------------------------
  // Test table
  // ----------------------------------------

  task automatic expect_store(input int row, input word_t addr, input word_t data);
    exp_addr[row][exp_n[row]] = addr;
    exp_data[row][exp_n[row]] = data;
    exp_n[row] = exp_n[row] + 1;
  endtask

  task automatic fill_table();
    word_t r;
    word_t sx;
    word_t x [8];
    logic [11:0] imm_a;
    logic [11:0] c;
    for (int row = 0; row < NUM_ROWS; row++) begin
      // Unused slots end the program
      for (int i = 0; i < MAX_PROG; i++) begin
        prog_tab[row][i] = EBREAK_INSTR;
      end
      init_tab[row] = $random(seed);
      exp_n[row]    = 0;
    end
    r     = $random(seed);
    imm_a = r[11:0];
    r     = $random(seed);
    c     = r[11:0];

    // Row 0 runs a dependent ALU chain and stores every result
    prog_tab[0][0] = i_type(12'h100, 5'd0, 3'b010, 5'd1, OPC_LOAD);
    prog_tab[0][1] = i_type(imm_a, 5'd1, 3'b000, 5'd2, OPC_OP_IMM);
    prog_tab[0][2] = r_type(7'h00, 5'd1, 5'd2, 3'b000, 5'd3);
    prog_tab[0][3] = r_type(7'h20, 5'd2, 5'd3, 3'b000, 5'd4);
    prog_tab[0][4] = r_type(7'h00, 5'd2, 5'd4, 3'b111, 5'd5);
    prog_tab[0][5] = r_type(7'h00, 5'd3, 5'd5, 3'b110, 5'd6);
    prog_tab[0][6] = r_type(7'h00, 5'd1, 5'd6, 3'b100, 5'd7);
    sx   = {{20{imm_a[11]}}, imm_a};
    x[1] = init_tab[0];
    x[2] = x[1] + sx;
    x[3] = x[2] + x[1];
    x[4] = x[3] - x[2];
    x[5] = x[4] & x[2];
    x[6] = x[5] | x[3];
    x[7] = x[6] ^ x[1];
    for (int k = 0; k < 6; k++) begin
      prog_tab[0][7 + k] = s_type(12'(12'h200 + 4 * k), 5'(k + 2), 5'd0);
      expect_store(0, 32'(32'h200 + 4 * k), x[k + 2]);
    end

    // Row 1 uses a loaded word at once and checks that x0 stays zero
    prog_tab[1][0] = i_type(c, 5'd0, 3'b000, 5'd3, OPC_OP_IMM);
    prog_tab[1][1] = i_type(12'h100, 5'd0, 3'b010, 5'd1, OPC_LOAD);
    prog_tab[1][2] = r_type(7'h00, 5'd3, 5'd1, 3'b000, 5'd2);
    prog_tab[1][3] = s_type(12'h020, 5'd2, 5'd0);
    prog_tab[1][4] = i_type(12'h055, 5'd0, 3'b000, 5'd0, OPC_OP_IMM);
    prog_tab[1][5] = i_type(12'h007, 5'd1, 3'b000, 5'd0, OPC_OP_IMM);
    prog_tab[1][6] = s_type(12'h024, 5'd0, 5'd0);
    expect_store(1, 32'h20, init_tab[1] + {{20{c[11]}}, c});
    expect_store(1, 32'h24, 32'h0);

    // Row 2 has a taken BEQ over two stores and a BEQ that falls through
    prog_tab[2][0] = i_type(12'h100, 5'd0, 3'b010, 5'd1, OPC_LOAD);
    prog_tab[2][1] = i_type(12'h000, 5'd1, 3'b000, 5'd2, OPC_OP_IMM);
    prog_tab[2][2] = b_type(13'd12, 5'd2, 5'd1);
    prog_tab[2][3] = s_type(12'h030, 5'd1, 5'd0);
    prog_tab[2][4] = s_type(12'h034, 5'd2, 5'd0);
    prog_tab[2][5] = i_type(12'h001, 5'd1, 3'b000, 5'd3, OPC_OP_IMM);
    prog_tab[2][6] = b_type(13'd8, 5'd3, 5'd1);
    prog_tab[2][7] = s_type(12'h038, 5'd3, 5'd0);
    prog_tab[2][8] = s_type(12'h03c, 5'd1, 5'd0);
    expect_store(2, 32'h38, init_tab[2] + 32'd1);
    expect_store(2, 32'h3c, init_tab[2]);

    // Row 3 has stores behind EBREAK that never issue
    prog_tab[3][0] = i_type(12'h100, 5'd0, 3'b010, 5'd1, OPC_LOAD);
    prog_tab[3][1] = s_type(12'h040, 5'd1, 5'd0);
    prog_tab[3][2] = EBREAK_INSTR;
    prog_tab[3][3] = s_type(12'h044, 5'd1, 5'd0);
    prog_tab[3][4] = s_type(12'h048, 5'd1, 5'd0);
    expect_store(3, 32'h40, init_tab[3]);
  endtask

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // ----------------------------------------
  // Run loop
  // ----------------------------------------

  task automatic apply_reset(input int row);
    @(posedge clk);
    rst_n <= 1'b0;
    @(negedge clk);
    // Program and data word go in while the core is held
    for (int i = 0; i < MAX_PROG; i++) begin
      imem[i] = prog_tab[row][i];
    end
    data_word = init_tab[row];
    repeat (3) @(posedge clk);
    @(negedge clk);
    // Both memory ports are idle and ebreak is clear in reset
    check_bit("imem_ren", imem_ren, 1'b0);
    check_bit("dmem_ren", dmem_ren, 1'b0);
    check_bit("dmem_we", dmem_we, 1'b0);
    check_bit("ebreak", ebreak, 1'b0);
    @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic run_row(input int row);
    apply_reset(row);
    while (ebreak !== 1'b1) begin
      @(negedge clk);
    end
    // ebreak holds and nothing more reaches the data port
    repeat (8) begin
      @(negedge clk);
      check_bit("ebreak", ebreak, 1'b1);
    end
    check_count("store count", got_addr.size(), exp_n[row]);
    for (int i = 0; i < exp_n[row]; i++) begin
      check_word("dmem_waddr", got_addr[i], exp_addr[row][i]);
      check_word("dmem_wdata", got_data[i], exp_data[row][i]);
    end
  endtask

  initial begin
    fill_table();
    for (int row = 0; row < NUM_ROWS; row++) begin
      run_row(row);
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== src/rv_core.sv ====
`timescale 1ns/1ns

module rv_core #(
  parameter rv_pkg::word_t reset_pc = 32'h0000_0000
) (
  input  logic          clk,
  input  logic          rst_n,
  output logic          imem_ren,
  output rv_pkg::word_t imem_raddr,
  input  rv_pkg::word_t imem_rdata,
  output logic          dmem_ren,
  output rv_pkg::word_t dmem_raddr,
  input  rv_pkg::word_t dmem_rdata,
  output logic          dmem_we,
  output rv_pkg::word_t dmem_waddr,
  output rv_pkg::word_t dmem_wdata,
  output logic          ebreak
);
  import rv_pkg::*;

  // IF -> ID
  word_t    instr;
  word_t    instr_pc;
  logic     instr_valid;
  // ID -> hazard
  reg_idx_t rs1;
  reg_idx_t rs2;
  logic     rs1_used;
  logic     rs2_used;
  logic     halt;
  // Pipeline control
  logic     stall;
  logic     redirect;
  word_t    redirect_pc;
  // WB -> register file
  logic     wb_we;
  reg_idx_t wb_rd;
  word_t    wb_data;

  decode_bus dbus ();
  exec_bus   xbus ();

  // ----------------------------------------
  // Pipeline stages
  // ----------------------------------------

  rv_fetch #(.reset_pc(reset_pc)) fetch0 (
    .clk, .rst_n, .stall, .redirect, .redirect_pc, .halt,
    .imem_ren, .imem_raddr, .imem_rdata, .instr, .instr_pc, .instr_valid
  );

  rv_decode decode0 (
    .clk, .rst_n, .instr, .instr_pc, .instr_valid, .stall, .redirect,
    .wb_we, .wb_rd, .wb_data, .rs1, .rs2, .rs1_used, .rs2_used, .halt,
    .d(dbus.src)
  );

  rv_execute execute0 (
    .clk, .rst_n, .d(dbus.dst), .x(xbus.src), .redirect, .redirect_pc,
    .dmem_ren, .dmem_raddr, .dmem_we, .dmem_waddr, .dmem_wdata
  );

  rv_writeback writeback0 (
    .clk, .rst_n, .x(xbus.dst), .dmem_rdata, .wb_we, .wb_rd, .wb_data, .ebreak
  );

  // EX destination taken straight from the ID/EX register
  rv_hazard hazard0 (
    .clk, .rst_n, .rs1, .rs2, .rs1_used, .rs2_used, .m(xbus.mon),
    .ex_rd(dbus.rd), .ex_reg_write(dbus.reg_write), .ex_valid(dbus.valid),
    .redirect, .stall
  );

endmodule

// ==== src/rv_hazard.sv ====
`timescale 1ns/1ns

module rv_hazard (
  input  logic             clk,
  input  logic             rst_n,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  logic             rs1_used,
  input  logic             rs2_used,
  exec_bus.mon             m,
  input  rv_pkg::reg_idx_t ex_rd,
  input  logic             ex_reg_write,
  input  logic             ex_valid,
  input  logic             redirect,
  output logic             stall
);
  import rv_pkg::*;

  logic ex_write;
  logic mem_write;
  logic rs1_hazard;
  logic rs2_hazard;

  // Pending writers in EX and MEM, WB is covered by write-through
  assign ex_write  = ex_valid && ex_reg_write;
  assign mem_write = m.valid && m.reg_write;

  // RAW match on each source, x0 never conflicts
  assign rs1_hazard = rs1_used && (rs1 != '0) &&
                      ((ex_write && (ex_rd == rs1)) || (mem_write && (m.rd == rs1)));
  assign rs2_hazard = rs2_used && (rs2 != '0) &&
                      ((ex_write && (ex_rd == rs2)) || (mem_write && (m.rd == rs2)));

  // Flush wins, the stalled instruction is squashed anyway
  assign stall = (rs1_hazard || rs2_hazard) && !redirect;

  a_stall_vs_flush : assert property (@(posedge clk) disable iff (!rst_n)
    !(stall && redirect));

  // A stall must put a bubble into EX
  a_stall_bubble : assert property (@(posedge clk) disable iff (!rst_n)
    stall |=> !ex_valid);

endmodule

// ==== src/rv_writeback.sv ====
`timescale 1ns/1ns

module rv_writeback (
  input  logic             clk,
  input  logic             rst_n,
  exec_bus.dst             x,
  input  rv_pkg::word_t    dmem_rdata,
  output logic             wb_we,
  output rv_pkg::reg_idx_t wb_rd,
  output rv_pkg::word_t    wb_data,
  output logic             ebreak
);
  import rv_pkg::*;

  // Result of the instruction now in MEM
  word_t mem_result;
  logic  wb_valid;
  logic  wb_reg_write;

  // ----------------------------------------
  // MEM stage
  // ----------------------------------------

  // Loads take the word returned from memory this cycle
  assign mem_result = x.is_load ? dmem_rdata : x.result;

  // ----------------------------------------
  // MEM/WB register
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
      ebreak   <= 1'b0;
    end else begin
      wb_valid <= x.valid;
      // Sticky until reset, high while EBREAK sits in WB
      if (x.valid && x.is_ebreak) begin
        ebreak <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    wb_rd        <= x.rd;
    wb_reg_write <= x.reg_write;
    wb_data      <= mem_result;
  end

  // Register write port, also read by the write-through path in decode
  assign wb_we = wb_valid && wb_reg_write;

  // Nothing younger than EBREAK reaches MEM
  a_drained : assert property (@(posedge clk) disable iff (!rst_n)
    ebreak |-> !x.valid);

endmodule

// ==== src/rv_execute.sv ====
`timescale 1ns/1ns

module rv_execute (
  input  logic          clk,
  input  logic          rst_n,
  decode_bus.dst        d,
  exec_bus.src          x,
  output logic          redirect,
  output rv_pkg::word_t redirect_pc,
  output logic          dmem_ren,
  output rv_pkg::word_t dmem_raddr,
  output logic          dmem_we,
  output rv_pkg::word_t dmem_waddr,
  output rv_pkg::word_t dmem_wdata
);
  import rv_pkg::*;

  word_t op_b;
  word_t alu_result;
  logic  rs_equal;

  // ----------------------------------------
  // ALU
  // ----------------------------------------

  assign op_b = d.use_imm ? d.imm : d.rs2_data;

  always_comb begin
    case (d.alu_op)
      ALU_SUB: alu_result = d.rs1_data - op_b;
      ALU_AND: alu_result = d.rs1_data & op_b;
      ALU_OR:  alu_result = d.rs1_data | op_b;
      ALU_XOR: alu_result = d.rs1_data ^ op_b;
      default: alu_result = d.rs1_data + op_b;
    endcase
  end

  // ----------------------------------------
  // Branch resolution
  // ----------------------------------------

  assign rs_equal = (d.rs1_data == d.rs2_data);

  // Taken BEQ, lasts one cycle since EX gets a bubble next
  assign redirect    = d.valid && d.is_branch && rs_equal;
  assign redirect_pc = d.pc + d.imm;

  // ----------------------------------------
  // Data memory requests
  // ----------------------------------------

  // Load data comes back while the load is in MEM
  assign dmem_ren   = d.valid && d.is_load;
  assign dmem_raddr = alu_result;
  assign dmem_we    = d.valid && d.is_store;
  assign dmem_waddr = alu_result;
  assign dmem_wdata = d.rs2_data;

  // ----------------------------------------
  // EX/MEM register
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x.valid <= 1'b0;
    end else begin
      x.valid <= d.valid;
    end
  end

  always_ff @(posedge clk) begin
    x.rd        <= d.rd;
    x.reg_write <= d.reg_write;
    x.is_load   <= d.is_load;
    x.is_ebreak <= d.is_ebreak;
    x.result    <= alu_result;
  end

  // One data access per cycle
  a_single_access : assert property (@(posedge clk) disable iff (!rst_n)
    !(dmem_ren && dmem_we));

  // Decode must squash the instruction behind a taken branch
  a_flush_bubble : assert property (@(posedge clk) disable iff (!rst_n)
    redirect |=> !d.valid);

endmodule

// ==== src/rv_decode.sv ====
`timescale 1ns/1ns

module rv_decode (
  input  logic             clk,
  input  logic             rst_n,
  input  rv_pkg::word_t    instr,
  input  rv_pkg::word_t    instr_pc,
  input  logic             instr_valid,
  input  logic             stall,
  input  logic             redirect,
  input  logic             wb_we,
  input  rv_pkg::reg_idx_t wb_rd,
  input  rv_pkg::word_t    wb_data,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2,
  output logic             rs1_used,
  output logic             rs2_used,
  output logic             halt,
  decode_bus.src           d
);
  import rv_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  reg_idx_t   rd;
  alu_op_e    alu_op;
  logic       use_imm;
  logic       is_load;
  logic       is_store;
  logic       is_branch;
  logic       is_ebreak;
  logic       reg_write;
  logic       uses_rs1;
  logic       uses_rs2;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm;
  word_t      regs [32];
  logic       advance;

  // ----------------------------------------
  // Field extraction
  // ----------------------------------------

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  // Sign-extended immediates
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

  // ----------------------------------------
  // Control decode
  // ----------------------------------------

  always_comb begin
    alu_op    = ALU_ADD;
    use_imm   = 1'b0;
    is_load   = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    is_ebreak = 1'b0;
    reg_write = 1'b0;
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    imm       = imm_i;
    case (opcode)
      OPC_OP: begin
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        reg_write = 1'b1;
        case (funct3)
          3'b000:  alu_op = instr[30] ? ALU_SUB : ALU_ADD;
          3'b100:  alu_op = ALU_XOR;
          3'b110:  alu_op = ALU_OR;
          3'b111:  alu_op = ALU_AND;
          // Unsupported R-type ops retire as no-ops
          default: reg_write = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        // Only ADDI
        uses_rs1  = 1'b1;
        use_imm   = 1'b1;
        reg_write = (funct3 == 3'b000);
      end
      OPC_LOAD: begin
        uses_rs1  = 1'b1;
        use_imm   = 1'b1;
        is_load   = 1'b1;
        reg_write = 1'b1;
      end
      OPC_STORE: begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        use_imm  = 1'b1;
        is_store = 1'b1;
        imm      = imm_s;
      end
      OPC_BRANCH: begin
        // BEQ only, compare done in EX
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        is_branch = (funct3 == 3'b000);
        imm       = imm_b;
      end
      OPC_SYSTEM: is_ebreak = (instr == EBREAK_INSTR);
      default: ;
    endcase
  end

  // Sources for the hazard unit
  assign rs1_used = instr_valid && uses_rs1;
  assign rs2_used = instr_valid && uses_rs2;

  // ----------------------------------------
  // Register file
  // ----------------------------------------

  // x0 reads zero, same-cycle WB write passes through
  function automatic word_t read_port(input reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end else if (wb_we && (wb_rd == idx)) begin
      return wb_data;
    end
    return regs[idx];
  endfunction

  always_ff @(posedge clk) begin
    if (wb_we && (wb_rd != '0)) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // ----------------------------------------
  // ID/EX register
  // ----------------------------------------

  // Bubble into EX on stall or flush
  assign advance = instr_valid && !stall && !redirect;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      d.valid <= 1'b0;
      halt    <= 1'b0;
    end else begin
      d.valid <= advance;
      if (advance && is_ebreak) begin
        halt <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    d.alu_op    <= alu_op;
    d.use_imm   <= use_imm;
    d.is_load   <= is_load;
    d.is_store  <= is_store;
    d.is_branch <= is_branch;
    d.is_ebreak <= is_ebreak;
    d.rd        <= rd;
    // Writes to x0 are dropped here so hazards never match x0
    d.reg_write <= reg_write && (rd != '0);
    d.rs1_data  <= read_port(rs1);
    d.rs2_data  <= read_port(rs2);
    d.imm       <= imm;
    d.pc        <= instr_pc;
  end

endmodule

// ==== src/rv_fetch.sv ====
`timescale 1ns/1ns

module rv_fetch #(
  parameter rv_pkg::word_t reset_pc = 32'h0000_0000
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          stall,
  input  logic          redirect,
  input  rv_pkg::word_t redirect_pc,
  input  logic          halt,
  output logic          imem_ren,
  output rv_pkg::word_t imem_raddr,
  input  rv_pkg::word_t imem_rdata,
  output rv_pkg::word_t instr,
  output rv_pkg::word_t instr_pc,
  output logic          instr_valid
);
  import rv_pkg::*;

  // Next address to request
  word_t pc;
  // PC of the word now returning from memory
  word_t req_pc;
  logic  req_valid;
  // Set after the first cycle out of reset
  logic  run;
  // Word kept while decode is stalled
  word_t hold_instr;
  logic  held;

  // No request while stalled, redirected or halted
  assign imem_ren   = run && !halt && !stall && !redirect;
  assign imem_raddr = pc;

  // Pair the returning word with its PC
  assign instr       = !req_valid ? NOP_INSTR : (held ? hold_instr : imem_rdata);
  assign instr_pc    = req_pc;
  assign instr_valid = req_valid && !halt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run       <= 1'b0;
      pc        <= reset_pc;
      req_valid <= 1'b0;
      held      <= 1'b0;
    end else begin
      run <= 1'b1;
      if (redirect) begin
        // Word in flight is dropped
        pc        <= redirect_pc;
        req_valid <= 1'b0;
        held      <= 1'b0;
      end else if (stall) begin
        held <= 1'b1;
      end else begin
        req_valid <= imem_ren;
        held      <= 1'b0;
        if (imem_ren) begin
          pc <= pc + 32'd4;
        end
      end
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (imem_ren) begin
      req_pc <= pc;
    end
    // Memory does not repeat the word, so catch it on the first stalled cycle
    if (stall && !held) begin
      hold_instr <= imem_rdata;
    end
  end

  // Once EBREAK has left decode no further requests go out
  a_halt_quiet : assert property (@(posedge clk) disable iff (!rst_n)
    halt |=> halt && !imem_ren);

endmodule

// ==== src/rv_stage_bus.sv ====
`timescale 1ns/1ns

// ID/EX pipeline register contents
interface decode_bus;
  import rv_pkg::*;

  logic     valid;
  alu_op_e  alu_op;
  // Operand B from the immediate instead of rs2
  logic     use_imm;
  logic     is_load;
  logic     is_store;
  logic     is_branch;
  logic     is_ebreak;
  reg_idx_t rd;
  logic     reg_write;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    imm;
  word_t    pc;

  modport src(
    output valid, alu_op, use_imm, is_load, is_store, is_branch, is_ebreak,
    output rd, reg_write, rs1_data, rs2_data, imm, pc
  );

  modport dst(
    input valid, alu_op, use_imm, is_load, is_store, is_branch, is_ebreak,
    input rd, reg_write, rs1_data, rs2_data, imm, pc
  );
endinterface

// EX/MEM pipeline register contents
interface exec_bus;
  import rv_pkg::*;

  logic     valid;
  reg_idx_t rd;
  logic     reg_write;
  logic     is_load;
  logic     is_ebreak;
  // ALU result, or the address for loads and stores
  word_t    result;

  modport src(output valid, rd, reg_write, is_load, is_ebreak, result);
  modport dst(input valid, rd, reg_write, is_load, is_ebreak, result);
  // Hazard unit only looks at the destination
  modport mon(input valid, rd, reg_write);
endinterface

// ==== src/rv_pkg.sv ====
package rv_pkg;

  // ----------------------------------------
  // Basic types
  // ----------------------------------------

  // Data, address or instruction word
  typedef logic [31:0] word_t;

  // Register file index
  typedef logic [4:0] reg_idx_t;

  // ----------------------------------------
  // Encodings
  // ----------------------------------------

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_BRANCH = 7'b1100011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // ALU operations
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_e;

  // ADDI x0,x0,0 presented to decode when no word is valid
  localparam word_t NOP_INSTR = 32'h0000_0013;

  // EBREAK, ends a program
  localparam word_t EBREAK_INSTR = 32'h0010_0073;

endpackage
